/* src/bip_pkg.sv */
package bip_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths.
  ////////////////////////////////////////////////////////////////////////////

  localparam int WORD_BITS    = 16;  // Accumulator and data word.
  localparam int OPCODE_BITS  = 5;   // Upper field of an instruction.
  localparam int OPERAND_BITS = 11;  // Lower field, address or immediate.

  // Signed data word.
  typedef logic signed [WORD_BITS-1:0] word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction format.
  ////////////////////////////////////////////////////////////////////////////

  // Unlisted codes run as a no-operation.
  typedef enum logic [OPCODE_BITS-1:0] {
    OP_HLT  = 5'd0,  // Stop and hold.
    OP_STO  = 5'd1,  // Mem[op] <= acc.
    OP_LD   = 5'd2,  // Acc <= mem[op].
    OP_LDI  = 5'd3,  // Acc <= sext(op).
    OP_ADD  = 5'd4,  // Acc <= acc + mem[op].
    OP_ADDI = 5'd5,  // Acc <= acc + sext(op).
    OP_SUB  = 5'd6,  // Acc <= acc - mem[op].
    OP_SUBI = 5'd7   // Acc <= acc - sext(op).
  } opcode_t;

  typedef struct packed {
    opcode_t                 opcode;   // Bits 15..11.
    logic [OPERAND_BITS-1:0] operand;  // Bits 10..0.
  } instr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath control.
  ////////////////////////////////////////////////////////////////////////////

  // Accumulator source, mux A.
  typedef enum logic [1:0] {
    SEL_A_MEM = 2'd0,
    SEL_A_IMM = 2'd1,
    SEL_A_ALU = 2'd2
  } sel_a_t;

  // Second ALU operand, mux B.
  typedef enum logic {
    SEL_B_MEM = 1'b0,
    SEL_B_IMM = 1'b1
  } sel_b_t;

  typedef enum logic [1:0] {
    ALU_PASS = 2'd0,
    ALU_ADD  = 2'd1,
    ALU_SUB  = 2'd2
  } alu_op_t;

  // Control word from decode.
  typedef struct packed {
    sel_a_t  sel_a;
    sel_b_t  sel_b;
    alu_op_t alu_op;
    logic    wr_acc;  // Accumulator load.
    logic    wr_ram;  // Data memory write strobe.
  } ctrl_t;

endpackage

/* src/bip_memory.sv */
`timescale 1ns/1ps

// Generic single-port-write RAM.
// One copy holds instructions, another holds data words.
module bip_memory #(
  parameter type t_payload = logic [15:0],  // Word stored per entry.
  parameter int  ADDR_BITS = 10             // Depth is 2**ADDR_BITS.
) (
  input  logic                 i_clock,
  input  logic                 i_write,   // Write strobe.
  input  logic [ADDR_BITS-1:0] i_waddr,
  input  t_payload             i_wdata,
  input  logic [ADDR_BITS-1:0] i_raddr,
  output t_payload             o_rdata
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  // Storage array.
  t_payload mem [DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // Write port.
  ////////////////////////////////////////////////////////////////////////////

  // Takes effect on the edge.
  always_ff @(posedge i_clock) begin
    if (i_write) begin
      mem[i_waddr] <= i_wdata;  // Single entry per cycle.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port.
  ////////////////////////////////////////////////////////////////////////////

  // No read latency.
  // A write to the read address shows after the edge.
  assign o_rdata = mem[i_raddr];

endmodule

/* src/bip_datapath.sv */
`timescale 1ns/1ps

// Accumulator datapath of the BIP.
// Sign extension, two muxes, an add/sub unit and the ACC register.
module bip_datapath (
  input  logic                              i_clock,
  input  logic                              i_reset,      // Sync, active low.
  input  bip_pkg::ctrl_t                    i_ctrl,       // From decode.
  input  logic [bip_pkg::OPERAND_BITS-1:0]  i_operand,    // Instruction low field.
  input  bip_pkg::word_t                    i_mem_rdata,  // Data memory read.
  output bip_pkg::word_t                    o_mem_wdata,  // Data memory write.
  output bip_pkg::word_t                    o_acc
);

  import bip_pkg::*;

  localparam int EXT_BITS = WORD_BITS - OPERAND_BITS;  // Replicated sign bits.

  word_t acc;         // Accumulator.
  word_t imm;         // Sign extended operand.
  word_t mux_b;       // Second ALU input.
  word_t alu_result;
  word_t mux_a;       // Next accumulator value.

  ////////////////////////////////////////////////////////////////////////////
  // Operand path.
  ////////////////////////////////////////////////////////////////////////////

  // Sign extension of the 11 bit immediate.
  assign imm = {{EXT_BITS{i_operand[OPERAND_BITS-1]}}, i_operand};

  always_comb begin
    case (i_ctrl.sel_b)
      SEL_B_IMM: mux_b = imm;
      default:   mux_b = i_mem_rdata;  // Memory operand.
    endcase
  end

  // Add/sub unit.
  // Result wraps at 16 bits.
  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD: alu_result = acc + mux_b;
      ALU_SUB: alu_result = acc - mux_b;
      default: alu_result = acc;  // Pass.
    endcase
  end

  // Accumulator source select.
  always_comb begin
    case (i_ctrl.sel_a)
      SEL_A_MEM: mux_a = i_mem_rdata;   // LD.
      SEL_A_IMM: mux_a = imm;           // LDI.
      default:   mux_a = alu_result;    // Arithmetic.
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator register.
  ////////////////////////////////////////////////////////////////////////////

  // Level enable, so back to back writes all land.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      acc <= '0;
    end else if (i_ctrl.wr_acc) begin
      acc <= mux_a;
    end
  end

  assign o_mem_wdata = acc;  // STO source.
  assign o_acc       = acc;  // Observed at the top.

endmodule

/* src/bip_control.sv */
`timescale 1ns/1ps

// Control unit of the BIP.
// Program loading over a four-phase port, PC and decode.
module bip_control #(
  parameter int PROG_ADDR_BITS = 11
) (
  input  logic                      i_clock,
  input  logic                      i_reset,       // Sync, active low.
  input  logic                      i_run,         // High runs, low loads.
  input  logic                      i_load_req,
  input  bip_pkg::instr_t           i_load_word,
  output logic                      o_load_ack,
  input  bip_pkg::opcode_t          i_opcode,      // Current instruction.
  output logic [PROG_ADDR_BITS-1:0] o_pc,
  output logic                      o_prog_write,
  output logic [PROG_ADDR_BITS-1:0] o_prog_waddr,
  output bip_pkg::instr_t           o_prog_wdata,
  output bip_pkg::ctrl_t            o_ctrl,
  output logic                      o_halted
);

  import bip_pkg::*;

  logic [PROG_ADDR_BITS-1:0] pc;
  logic [PROG_ADDR_BITS-1:0] load_addr;  // Next program slot to fill.
  logic                      ack;
  logic                      halted;
  logic                      load_accept;  // Req seen with ack low.
  logic                      running;      // One instruction completes.
  logic                      is_hlt;
  ctrl_t                     dec;          // Decode before write gating.

  assign running     = i_run && !halted;
  assign load_accept = !i_run && i_load_req && !ack;
  assign is_hlt      = (i_opcode == OP_HLT);

  ////////////////////////////////////////////////////////////////////////////
  // Load port.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      ack       <= 1'b0;
      load_addr <= '0;
    end else if (i_run) begin
      ack       <= 1'b0;  // Req ignored while running.
      load_addr <= '0;    // Next load starts at slot 0.
    end else if (load_accept) begin
      ack       <= 1'b1;  // Phase 2.
      load_addr <= load_addr + 1'b1;
    end else if (ack && !i_load_req) begin
      ack       <= 1'b0;  // Phase 4.
    end
  end

  // Word lands on the same edge that raises ack.
  assign o_prog_write = load_accept;
  assign o_prog_waddr = load_addr;
  assign o_prog_wdata = i_load_word;
  assign o_load_ack   = ack;

  ////////////////////////////////////////////////////////////////////////////
  // PC and halt.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (!i_run) begin
      pc     <= '0;    // Back to load mode.
      halted <= 1'b0;
    end else if (running) begin
      if (is_hlt) begin
        halted <= 1'b1;  // PC stays on the HLT.
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  assign o_pc     = pc;
  assign o_halted = halted;

  ////////////////////////////////////////////////////////////////////////////
  // Decode.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults give a no-operation.
    dec.sel_a  = SEL_A_MEM;
    dec.sel_b  = SEL_B_MEM;
    dec.alu_op = ALU_PASS;
    dec.wr_acc = 1'b0;
    dec.wr_ram = 1'b0;
    case (i_opcode)
      OP_STO: dec.wr_ram = 1'b1;
      OP_LD: begin
        dec.sel_a  = SEL_A_MEM;
        dec.wr_acc = 1'b1;
      end
      OP_LDI: begin
        dec.sel_a  = SEL_A_IMM;
        dec.wr_acc = 1'b1;
      end
      OP_ADD, OP_ADDI: begin
        dec.sel_a  = SEL_A_ALU;
        dec.sel_b  = (i_opcode == OP_ADDI) ? SEL_B_IMM : SEL_B_MEM;
        dec.alu_op = ALU_ADD;
        dec.wr_acc = 1'b1;
      end
      OP_SUB, OP_SUBI: begin
        dec.sel_a  = SEL_A_ALU;
        dec.sel_b  = (i_opcode == OP_SUBI) ? SEL_B_IMM : SEL_B_MEM;
        dec.alu_op = ALU_SUB;
        dec.wr_acc = 1'b1;
      end
      default: ;  // HLT and unused codes.
    endcase
  end

  // No writes outside of running.
  always_comb begin
    o_ctrl        = dec;
    o_ctrl.wr_acc = dec.wr_acc && running;
    o_ctrl.wr_ram = dec.wr_ram && running;
  end

endmodule

/* src/bip_cpu.sv */
`timescale 1ns/1ps

// BIP top level.
// Control, datapath, program memory and data memory.
module bip_cpu #(
  parameter int PROG_ADDR_BITS = 11,  // Program depth 2048.
  parameter int DATA_ADDR_BITS = 10   // Data depth 1024, fits in the operand.
) (
  input  logic            i_clock,
  input  logic            i_reset,      // Sync, active low.
  input  logic            i_run,
  input  logic            i_load_req,
  input  bip_pkg::instr_t i_load_word,
  output logic            o_load_ack,
  output bip_pkg::word_t  o_acc,
  output logic            o_halted
);

  import bip_pkg::*;

  logic [PROG_ADDR_BITS-1:0] pc;
  logic                      prog_write;
  logic [PROG_ADDR_BITS-1:0] prog_waddr;
  instr_t                    prog_wdata;
  instr_t                    instr;       // Instruction at the PC.
  ctrl_t                     ctrl;
  word_t                     mem_rdata;   // Data memory to datapath.
  word_t                     mem_wdata;   // Accumulator to data memory.

  ////////////////////////////////////////////////////////////////////////////
  // Control and datapath.
  ////////////////////////////////////////////////////////////////////////////

  bip_control #(
    .PROG_ADDR_BITS (PROG_ADDR_BITS)
  ) u_control (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_run        (i_run),
    .i_load_req   (i_load_req),
    .i_load_word  (i_load_word),
    .o_load_ack   (o_load_ack),
    .i_opcode     (instr.opcode),    // Upper field.
    .o_pc         (pc),
    .o_prog_write (prog_write),
    .o_prog_waddr (prog_waddr),
    .o_prog_wdata (prog_wdata),
    .o_ctrl       (ctrl),
    .o_halted     (o_halted)
  );

  bip_datapath u_datapath (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_ctrl      (ctrl),
    .i_operand   (instr.operand),    // Lower field.
    .i_mem_rdata (mem_rdata),
    .o_mem_wdata (mem_wdata),
    .o_acc       (o_acc)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memories.
  ////////////////////////////////////////////////////////////////////////////

  bip_memory #(
    .t_payload (instr_t),
    .ADDR_BITS (PROG_ADDR_BITS)
  ) u_prog_mem (
    .i_clock (i_clock),
    .i_write (prog_write),
    .i_waddr (prog_waddr),
    .i_wdata (prog_wdata),
    .i_raddr (pc),
    .o_rdata (instr)
  );

  // Both ports addressed by the low operand bits.
  bip_memory #(
    .t_payload (word_t),
    .ADDR_BITS (DATA_ADDR_BITS)
  ) u_data_mem (
    .i_clock (i_clock),
    .i_write (ctrl.wr_ram),
    .i_waddr (instr.operand[DATA_ADDR_BITS-1:0]),
    .i_wdata (mem_wdata),
    .i_raddr (instr.operand[DATA_ADDR_BITS-1:0]),
    .o_rdata (mem_rdata)
  );

endmodule

/* dv/bip_cpu_tb.sv */
`timescale 1ns/1ps

// Directed testbench for the BIP accumulator CPU.
module bip_cpu_tb;

  import bip_pkg::*;

  localparam int DATA_ADDR_BITS = 10;  // DUT default.
  localparam int RAND_PROGS     = 5;
  localparam int RAND_LEN       = 40;  // Random words before the HLT.
  localparam int HS_LIMIT       = 20;  // Cycles allowed per handshake phase.
  // Words loaded over the whole run, test by test.
  localparam int TOTAL_WORDS = 1 + 4 + 35 + 13 + 5 + 6 + 33 + RAND_PROGS * (RAND_LEN + 1);
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 30 + 1000;

  logic   i_clock = 1'b0;
  logic   i_reset;
  logic   i_run;
  logic   i_load_req;
  instr_t i_load_word;
  logic   o_load_ack;
  word_t  o_acc;
  logic   o_halted;

  instr_t      prog_q [$];                       // Program under test.
  word_t       model_mem [2**DATA_ADDR_BITS];    // Reference data memory.
  word_t       model_acc = '0;                   // Reference accumulator.
  logic [31:0] lfsr_state = 32'he139_de6c;
  int          errors = 0;
  int          checks = 0;

  bip_cpu u_dut (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_run       (i_run),
    .i_load_req  (i_load_req),
    .i_load_word (i_load_word),
    .o_load_ack  (o_load_ack),
    .o_acc       (o_acc),
    .o_halted    (o_halted)
  );

  always #5 i_clock = ~i_clock;  // 10 ns period.

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers.
  ////////////////////////////////////////////////////////////////////////////

  // Galois step with taps of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] value;
    int          b;
    value = '0;
    for (b = 0; b < count; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic instr_t make_instr(input opcode_t op, input int value);
    instr_t word;
    word.opcode  = op;
    word.operand = value[OPERAND_BITS-1:0];  // Low 11 bits, two's complement.
    return word;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks.
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %0d (0x%h) actual %0d (0x%h)", name, exp, exp, act, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model.
  ////////////////////////////////////////////////////////////////////////////

  // Runs prog_q from slot 0 up to and including the first HLT.
  task automatic model_run(output int steps);
    instr_t                    word;
    word_t                     imm;
    logic [DATA_ADDR_BITS-1:0] addr;
    int                        i;
    logic                      done;
    steps = 0;
    i     = 0;
    done  = 1'b0;
    while (!done && i < prog_q.size()) begin
      word = prog_q[i];
      imm  = {{(WORD_BITS - OPERAND_BITS){word.operand[OPERAND_BITS-1]}}, word.operand};
      addr = word.operand[DATA_ADDR_BITS-1:0];  // Bit 10 is not decoded.
      steps++;
      case (word.opcode)
        OP_HLT:  done = 1'b1;
        OP_STO:  model_mem[addr] = model_acc;
        OP_LD:   model_acc = model_mem[addr];
        OP_LDI:  model_acc = imm;
        OP_ADD:  model_acc = model_acc + model_mem[addr];
        OP_ADDI: model_acc = model_acc + imm;
        OP_SUB:  model_acc = model_acc - model_mem[addr];
        OP_SUBI: model_acc = model_acc - imm;
        default: ;  // No-operation.
      endcase
      i++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks.
  ////////////////////////////////////////////////////////////////////////////

  // Four-phase load of every word in prog_q.
  task automatic load_program(input string name);
    int i;
    int waited;
    for (i = 0; i < prog_q.size(); i++) begin
      @(posedge i_clock);
      i_load_word <= prog_q[i];
      i_load_req  <= 1'b1;
      @(negedge i_clock);
      check_flag({name, " ack waits for req"}, 1'b0, o_load_ack);
      waited = 0;
      while (o_load_ack !== 1'b1 && waited < HS_LIMIT) begin
        @(negedge i_clock);
        waited++;
      end
      if (o_load_ack !== 1'b1) begin
        errors++;
        $display("%s: ack did not rise within %0d cycles at word %0d", name, HS_LIMIT, i);
      end
      @(posedge i_clock);
      i_load_req <= 1'b0;
      @(negedge i_clock);
      check_flag({name, " ack holds until req falls"}, 1'b1, o_load_ack);
      waited = 0;
      while (o_load_ack !== 1'b0 && waited < HS_LIMIT) begin
        @(negedge i_clock);
        waited++;
      end
      if (o_load_ack !== 1'b0) begin
        errors++;
        $display("%s: ack did not fall within %0d cycles at word %0d", name, HS_LIMIT, i);
      end
    end
  endtask

  // Raises i_run and counts edges until o_halted.
  task automatic run_program(input string name, output int cycles);
    @(posedge i_clock);
    i_run <= 1'b1;
    @(negedge i_clock);  // First edge that sees i_run high is next.
    cycles = 0;
    while (o_halted !== 1'b1 && cycles < prog_q.size() + 20) begin
      @(negedge i_clock);
      cycles++;
    end
    if (o_halted !== 1'b1) begin
      errors++;
      $display("%s: o_halted did not rise after %0d cycles", name, cycles);
    end
  endtask

  task automatic stop_run(input string name);
    @(posedge i_clock);
    i_run <= 1'b0;
    @(posedge i_clock);  // Edge that sees i_run low.
    @(negedge i_clock);
    check_flag({name, " halt clears"}, 1'b0, o_halted);
  endtask

  // Load, model, run, compare, then back to load mode.
  task automatic execute_program(input string name);
    int    steps;
    int    cycles;
    int    k;
    load_program(name);
    model_run(steps);
    run_program(name, cycles);
    check_count({name, " edges to halt"}, steps, cycles);
    check_word({name, " acc at halt"}, model_acc, o_acc);
    for (k = 0; k < 10; k++) begin
      @(negedge i_clock);
      check_word({name, " acc frozen"}, model_acc, o_acc);
    end
    check_flag({name, " still halted"}, 1'b1, o_halted);
    stop_run(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests.
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_and_handshake();
    int k;
    int steps;
    @(negedge i_clock);
    check_flag("reset ack", 1'b0, o_load_ack);
    check_flag("reset halted", 1'b0, o_halted);
    check_word("reset acc", '0, o_acc);
    prog_q.delete();
    prog_q.push_back(make_instr(OP_HLT, 0));
    load_program("handshake");
    // Req while running gets no ack.
    @(posedge i_clock);
    i_run       <= 1'b1;
    i_load_req  <= 1'b1;
    i_load_word <= make_instr(OP_LDI, 77);
    for (k = 0; k < 5; k++) begin
      @(negedge i_clock);
      check_flag("run ignores req", 1'b0, o_load_ack);
    end
    @(posedge i_clock);
    i_load_req <= 1'b0;
    model_run(steps);
    @(negedge i_clock);
    check_flag("lone HLT halts", 1'b1, o_halted);
    check_word("lone HLT acc", model_acc, o_acc);
    stop_run("handshake");
  endtask

  task automatic test_immediate();
    int k;
    prog_q.delete();
    prog_q.push_back(make_instr(OP_LDI, -1024));  // Most negative immediate.
    prog_q.push_back(make_instr(OP_ADDI, 7));
    prog_q.push_back(make_instr(OP_SUBI, -2));
    prog_q.push_back(make_instr(OP_HLT, 0));
    execute_program("immediate sign");
    // Climbs past 32767 to wrap.
    prog_q.delete();
    prog_q.push_back(make_instr(OP_LDI, 1023));  // Most positive immediate.
    for (k = 0; k < 32; k++) begin
      prog_q.push_back(make_instr(OP_ADDI, 1023));
    end
    prog_q.push_back(make_instr(OP_SUBI, 1));
    prog_q.push_back(make_instr(OP_HLT, 0));
    execute_program("immediate wrap");
  endtask

  task automatic test_memory();
    prog_q.delete();
    prog_q.push_back(make_instr(OP_LDI, 100));
    prog_q.push_back(make_instr(OP_STO, 5));
    prog_q.push_back(make_instr(OP_LDI, -300));
    prog_q.push_back(make_instr(OP_STO, 9));
    prog_q.push_back(make_instr(OP_LDI, 0));
    prog_q.push_back(make_instr(OP_LD, 5));
    prog_q.push_back(make_instr(OP_ADD, 9));
    prog_q.push_back(make_instr(OP_ADD, 5));
    prog_q.push_back(make_instr(OP_SUB, 9));
    prog_q.push_back(make_instr(OP_STO, 12));
    prog_q.push_back(make_instr(OP_LD, 12'h40C));  // Aliases address 12.
    prog_q.push_back(make_instr(OP_ADD, 5));
    prog_q.push_back(make_instr(OP_HLT, 0));
    execute_program("memory");
  endtask

  task automatic test_halt();
    prog_q.delete();
    prog_q.push_back(make_instr(OP_LDI, 42));
    prog_q.push_back(make_instr(OP_ADDI, 3));
    prog_q.push_back(make_instr(OP_HLT, 0));
    prog_q.push_back(make_instr(OP_LDI, 7));  // Never reached.
    prog_q.push_back(make_instr(OP_HLT, 0));
    execute_program("halt");
  endtask

  // Second program is as long as the first, so a stale load address shows.
  task automatic test_reload();
    prog_q.delete();
    prog_q.push_back(make_instr(OP_LDI, 200));
    prog_q.push_back(make_instr(OP_ADDI, 5));
    prog_q.push_back(make_instr(OP_HLT, 0));
    execute_program("reload first");
    prog_q.delete();
    prog_q.push_back(make_instr(OP_ADDI, 10));  // Builds on the kept acc.
    prog_q.push_back(make_instr(OP_SUBI, -3));
    prog_q.push_back(make_instr(OP_HLT, 0));
    execute_program("reload second");
  endtask

  task automatic test_random();
    int      a;
    int      p;
    int      k;
    int      code;
    opcode_t op;
    // Defined values in the 16 word window used by memory operands.
    prog_q.delete();
    for (a = 0; a < 16; a++) begin
      prog_q.push_back(make_instr(OP_LDI, int'(lfsr_bits(11))));
      prog_q.push_back(make_instr(OP_STO, a));
    end
    prog_q.push_back(make_instr(OP_HLT, 0));
    execute_program("random init");
    for (p = 0; p < RAND_PROGS; p++) begin
      prog_q.delete();
      for (k = 0; k < RAND_LEN; k++) begin
        code = int'(lfsr_bits(3)) % 7 + 1;  // STO through SUBI.
        op   = opcode_t'(code[OPCODE_BITS-1:0]);
        if (op == OP_STO || op == OP_LD || op == OP_ADD || op == OP_SUB) begin
          prog_q.push_back(make_instr(op, int'(lfsr_bits(4))));
        end else begin
          prog_q.push_back(make_instr(op, int'(lfsr_bits(11))));
        end
      end
      prog_q.push_back(make_instr(OP_HLT, 0));
      execute_program($sformatf("random %0d", p));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog.
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    i_reset     = 1'b0;
    i_run       = 1'b0;
    i_load_req  = 1'b0;
    i_load_word = '0;
    repeat (4) @(posedge i_clock);
    i_reset <= 1'b1;  // Four edges in reset.
    test_reset_and_handshake();
    test_immediate();
    test_memory();
    test_halt();
    test_reload();
    test_random();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clock);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* files.f */
src/bip_pkg.sv
src/bip_memory.sv
src/bip_datapath.sv
src/bip_control.sv
src/bip_cpu.sv
dv/bip_cpu_tb.sv

/* Bender.yml */
package:
  name: bip_cpu

sources:
  # RTL in compile order.
  - src/bip_pkg.sv
  - src/bip_memory.sv
  - src/bip_datapath.sv
  - src/bip_control.sv
  - src/bip_cpu.sv

  # Testbench, top module bip_cpu_tb.
  - target: test
    files:
      - dv/bip_cpu_tb.sv
